// File: shift_stage.f
+incdir+include
source/shift_stage_pkg.sv
source/shift_operand_resolve.sv
source/shift_barrel.sv
source/shift_stage_reg.sv
source/shift_stage_top.sv
sim/shift_stage_tb.sv

// File: Makefile
# Verilator build and run for the shift stage testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= shift_stage_tb
FILELIST  ?= shift_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/shift_stage_tb.sv
//////////////////////////////////////////////////////////////////////
// Random-stimulus testbench for the shift stage top level.
// A cycle model predicts every output one clock after its inputs.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "shift_stage_params.svh"

module shift_stage_tb;

localparam int RESET_CYCLES   = 8;
localparam int RANDOM_ITEMS   = 3000;
localparam int PRIORITY_ITEMS = 600;
localparam int CHAIN_ITEMS    = 600;
localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 + RANDOM_ITEMS + PRIORITY_ITEMS
                                + CHAIN_ITEMS + 100;

// Stimulus modes.
localparam int MODE_RESET    = 0;
localparam int MODE_IDLE     = 1;
localparam int MODE_RANDOM   = 2;
localparam int MODE_PRIORITY = 3;
localparam int MODE_CHAIN    = 4;

logic i_clk, i_reset, i_clear_from_writeback, i_data_stall, i_clear_from_alu;
logic i_cpsr_ff_c, i_cpsr_nxt_c, i_flag_update, i_und, i_disable_shifter;
logic i_alu_dav_nxt;
shift_stage_pkg::cond_t     i_condition_code;
shift_stage_pkg::alu_op_t   i_alu_operation;
shift_stage_pkg::shift_op_t i_shift_operation;
logic [`SHIFT_IDX_W-1:0]  i_destination_index, i_mem_srcdest_index;
logic [`SHIFT_SRC_W-1:0]  i_alu_source, i_shift_source;
logic [`SHIFT_DATA_W-1:0] i_alu_source_value, i_shift_source_value, i_shift_length_value;
logic [`SHIFT_DATA_W-1:0] i_mem_srcdest_value, i_pc_plus_8, i_alu_value_nxt;

shift_stage_pkg::cond_t   o_condition_code_ff;
shift_stage_pkg::alu_op_t o_alu_operation_ff;
logic                     o_flag_update_ff, o_und_ff, o_shift_carry_ff;
logic [`SHIFT_IDX_W-1:0]  o_destination_index_ff;
logic [`SHIFT_DATA_W-1:0] o_alu_source_value_ff, o_mem_srcdest_value_ff;
logic [`SHIFT_DATA_W-1:0] o_shifted_source_value_ff;

// Model copy of the output register.
shift_stage_pkg::cond_t   m_cond;
shift_stage_pkg::alu_op_t m_op;
logic                     m_flag, m_und, m_carry;
logic [`SHIFT_IDX_W-1:0]  m_dest;
logic [`SHIFT_DATA_W-1:0] m_alu_val, m_mem_val, m_shifted;

logic [31:0] lfsr_state;
int          error_count, check_count, cycle_count;
string       test_name, item_test;

shift_stage_top u_dut (.*);

initial
begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
end

//////////////////////////////////////////////////////////////////////
// Random source. Taps 32, 22, 2, 1; one step per bit taken.
//////////////////////////////////////////////////////////////////////

function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
                lfsr_state = {lfsr_state[30:0],
                              lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
                bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
endfunction

// Mostly r0 to r3 so forwards hit often, sometimes the PC.
function automatic logic [`SHIFT_IDX_W-1:0] pick_index();
        logic [31:0] r;
        r = take_bits(3);
        if (r[2:0] >= 3'd6)
                return `SHIFT_IDX_W'(`SHIFT_PC_INDEX);
        return {2'b00, r[1:0]};
endfunction

// One in four descriptors is an immediate.
function automatic logic [`SHIFT_SRC_W-1:0] pick_source();
        logic [31:0] r;
        r = take_bits(2);
        if (r[1:0] == 2'd0)
                return {1'b1, take_bits(32)};
        return {29'b0, pick_index()};
endfunction

// Half the lengths hit a boundary amount, upper bits are noise.
function automatic logic [31:0] pick_length();
        logic [7:0]  table_amt [8];
        logic [31:0] r, upper;
        table_amt = '{8'd0, 8'd1, 8'd31, 8'd32, 8'd33, 8'd255, 8'd16, 8'd64};
        upper = take_bits(24);
        r = take_bits(1);
        if (r[0])
        begin
                r = take_bits(3);
                return {upper[23:0], table_amt[r[2:0]]};
        end
        r = take_bits(8);
        return {upper[23:0], r[7:0]};
endfunction

//////////////////////////////////////////////////////////////////////
// Reference model.
//////////////////////////////////////////////////////////////////////

// Immediate, then pc+8, then the ALU forward, then the issue value.
function automatic logic [31:0] resolve_model(input logic [32:0] desc, input logic [31:0] issued);
        if (desc[`SHIFT_IMMED_BIT])
                return desc[31:0];
        if (desc[3:0] == 4'(`SHIFT_PC_INDEX))
                return i_pc_plus_8;
        if (desc[3:0] == m_dest && i_alu_dav_nxt)
                return i_alu_value_nxt;
        return issued;
endfunction

task automatic shift_model(input logic [31:0] src, input logic [7:0] amt,
                           input shift_stage_pkg::shift_op_t op, input logic cin,
                           output logic [31:0] res, output logic cout);
        int          k;
        logic [4:0]  pos;
        logic [63:0] rot;
        k = int'(amt);
        res = src;
        cout = cin;
        case (op)
        shift_stage_pkg::LSL:
        begin
                pos = 5'(32 - k);
                if (k >= 1 && k <= 31)
                begin
                        res = src << k;
                        cout = src[pos];
                end
                else if (k >= 32)
                begin
                        res = '0;
                        cout = (k == 32) ? src[0] : 1'b0;
                end
        end
        shift_stage_pkg::LSR, shift_stage_pkg::ASR:
        begin
                pos = 5'(k - 1);
                if (k >= 1 && k <= 31)
                begin
                        if (op == shift_stage_pkg::ASR)
                                res = $signed(src) >>> k;
                        else
                                res = src >> k;
                        cout = src[pos];
                end
                else if (k >= 32)
                begin
                        // ASR fills with the sign. LSR keeps bit 31 as carry only at 32.
                        res = (op == shift_stage_pkg::ASR) ? {32{src[31]}} : 32'd0;
                        cout = (op == shift_stage_pkg::ASR || k == 32) ? src[31] : 1'b0;
                end
        end
        shift_stage_pkg::ROR:
        begin
                if (k != 0)
                begin
                        // Word doubled, so a right shift brings the low bits round to the top.
                        rot = {src, src} >> (k % 32);
                        res = rot[31:0];
                        cout = res[31];
                end
        end
        shift_stage_pkg::RRX:
        begin
                res = {cin, src[31:1]};
                cout = src[0];
        end
        default:
        begin
        end
        endcase
endtask

task automatic update_model();
        logic [31:0] alu_v, mem_v, sh_v;
        logic        sh_c;
        alu_v = resolve_model(i_alu_source, i_alu_source_value);
        mem_v = resolve_model({29'b0, i_mem_srcdest_index}, i_mem_srcdest_value);
        if (i_disable_shifter)
        begin
                sh_v = resolve_model(i_shift_source, i_shift_source_value);
                sh_c = i_cpsr_nxt_c;
        end
        else
                shift_model(i_shift_source_value, i_shift_length_value[7:0], i_shift_operation,
                            i_cpsr_ff_c, sh_v, sh_c);
        if (i_reset)
        begin
                m_cond = shift_stage_pkg::EQ;
                m_op = shift_stage_pkg::AND;
                {m_flag, m_und, m_carry, m_dest} = '0;
                {m_alu_val, m_mem_val, m_shifted} = '0;
        end
        else if (i_clear_from_writeback || (!i_data_stall && i_clear_from_alu))
        begin
                // Killed slot.
                m_cond = shift_stage_pkg::NV;
                m_und = 1'b0;
        end
        else if (!i_data_stall)
        begin
                m_cond = i_condition_code;
                m_op = i_alu_operation;
                m_flag = i_flag_update;
                m_und = i_und;
                m_dest = i_destination_index;
                m_alu_val = alu_v;
                m_mem_val = mem_v;
                m_shifted = sh_v;
                m_carry = sh_c;
        end
        item_test = test_name;
endtask

//////////////////////////////////////////////////////////////////////
// Checks and stimulus.
//////////////////////////////////////////////////////////////////////

task automatic check_field(input string field, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
                error_count++;
                $display("Fail %s %s: expected %h, actual %h", item_test, field, expected, actual);
        end
endtask

task automatic compare_outputs();
        check_field("condition", 32'(m_cond), 32'(o_condition_code_ff));
        check_field("alu_operation", 32'(m_op), 32'(o_alu_operation_ff));
        check_field("flag_update", 32'(m_flag), 32'(o_flag_update_ff));
        check_field("und", 32'(m_und), 32'(o_und_ff));
        check_field("destination", 32'(m_dest), 32'(o_destination_index_ff));
        check_field("alu_source_value", m_alu_val, o_alu_source_value_ff);
        check_field("mem_srcdest_value", m_mem_val, o_mem_srcdest_value_ff);
        check_field("shifted_value", m_shifted, o_shifted_source_value_ff);
        check_field("shift_carry", 32'(m_carry), 32'(o_shift_carry_ff));
endtask

task automatic zero_inputs();
        {i_clear_from_writeback, i_data_stall, i_clear_from_alu} = '0;
        {i_cpsr_ff_c, i_cpsr_nxt_c, i_flag_update, i_und, i_disable_shifter, i_alu_dav_nxt} = '0;
        i_condition_code = shift_stage_pkg::EQ;
        i_alu_operation = shift_stage_pkg::AND;
        i_shift_operation = shift_stage_pkg::LSL;
        {i_destination_index, i_mem_srcdest_index, i_alu_source, i_shift_source} = '0;
        {i_alu_source_value, i_shift_source_value, i_shift_length_value} = '0;
        {i_mem_srcdest_value, i_pc_plus_8, i_alu_value_nxt} = '0;
endtask

task automatic drive_inputs(input int mode);
        logic [31:0] r;
        logic [2:0]  sel;
        zero_inputs();
        i_reset = (mode == MODE_RESET);
        if (mode >= MODE_RANDOM)
        begin
                r = take_bits(4);
                i_condition_code = shift_stage_pkg::cond_t'(r[3:0]);
                r = take_bits(4);
                i_alu_operation = shift_stage_pkg::alu_op_t'({1'b0, r[3:0]});
                r = take_bits(3);
                sel = (r[2:0] > 3'd4) ? r[2:0] - 3'd4 : r[2:0];
                i_shift_operation = shift_stage_pkg::shift_op_t'(sel);
                r = take_bits(7);
                {i_flag_update, i_und, i_alu_dav_nxt, i_cpsr_ff_c, i_cpsr_nxt_c} = r[4:0];
                i_disable_shifter = (r[6:5] == 2'd0);
                i_destination_index = pick_index() & 4'd3;
                i_alu_source = pick_source();
                i_shift_source = pick_source();
                i_mem_srcdest_index = pick_index();
                i_alu_source_value = take_bits(32);
                i_shift_source_value = take_bits(32);
                i_shift_length_value = pick_length();
                i_mem_srcdest_value = take_bits(32);
                i_pc_plus_8 = take_bits(32);
                i_alu_value_nxt = take_bits(32);
        end
        if (mode == MODE_RANDOM)
        begin
                r = take_bits(9);
                i_clear_from_writeback = (r[2:0] == 3'd0);
                i_data_stall = (r[5:3] == 3'd0);
                i_clear_from_alu = (r[8:6] == 3'd0);
        end
        else if (mode == MODE_PRIORITY)
        begin
                r = take_bits(3);
                {i_clear_from_writeback, i_data_stall, i_clear_from_alu} = r[2:0];
        end
        else if (mode == MODE_CHAIN)
        begin
                // Every source names the item now held in the register.
                r = take_bits(4);
                i_destination_index = (r[3:0] == 4'd15) ? 4'd0 : r[3:0];
                i_alu_source = {29'b0, m_dest};
                i_shift_source = {29'b0, m_dest};
                i_mem_srcdest_index = m_dest;
                i_alu_dav_nxt = 1'b1;
        end
endtask

// Check the state left by the last edge, then drive the next item.
task automatic run_cycle(input int mode);
        @(negedge i_clk);
        compare_outputs();
        drive_inputs(mode);
        update_model();
endtask

initial
begin
        lfsr_state = 32'h195e_2418;
        error_count = 0;
        check_count = 0;
        zero_inputs();
        i_reset = 1'b1;
        test_name = "reset";
        update_model();
        repeat (RESET_CYCLES - 1) run_cycle(MODE_RESET);
        test_name = "idle_after_reset";
        repeat (2) run_cycle(MODE_IDLE);
        test_name = "random_resolve_shift";
        repeat (RANDOM_ITEMS) run_cycle(MODE_RANDOM);
        test_name = "stall_clear_priority";
        repeat (PRIORITY_ITEMS) run_cycle(MODE_PRIORITY);
        test_name = "forward_chain";
        repeat (CHAIN_ITEMS) run_cycle(MODE_CHAIN);
        @(negedge i_clk);
        compare_outputs();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
                $display("No errors");
        else
                $display("Errors found");
        $finish;
end

// Guard against a run that never reaches its end.
initial
begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
                @(posedge i_clk);
                cycle_count++;
        end
        error_count++;
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Errors found");
        $finish;
end

endmodule

// File: source/shift_stage_top.sv
//////////////////////////////////////////////////////////////////////
// Shift stage top level. Operand resolve and barrel shift feed the
// output register; one cycle from issue inputs to outputs.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "shift_stage_params.svh"

module shift_stage_top
(
        input  logic                      i_clk,
        input  logic                      i_reset,

        // Stall and clear, highest priority first.
        input  logic                      i_clear_from_writeback,
        input  logic                      i_data_stall,
        input  logic                      i_clear_from_alu,

        // Carry flag, registered and next-state.
        input  logic                      i_cpsr_ff_c,
        input  logic                      i_cpsr_nxt_c,

        // Issue packet.
        input  shift_stage_pkg::cond_t    i_condition_code,
        input  shift_stage_pkg::alu_op_t  i_alu_operation,
        input  shift_stage_pkg::shift_op_t i_shift_operation,
        input  logic                      i_flag_update,
        input  logic                      i_und,
        input  logic [`SHIFT_IDX_W-1:0]   i_destination_index,
        input  logic [`SHIFT_SRC_W-1:0]   i_alu_source,
        input  logic [`SHIFT_DATA_W-1:0]  i_alu_source_value,
        input  logic [`SHIFT_SRC_W-1:0]   i_shift_source,
        input  logic [`SHIFT_DATA_W-1:0]  i_shift_source_value,
        input  logic [`SHIFT_DATA_W-1:0]  i_shift_length_value,
        input  logic [`SHIFT_IDX_W-1:0]   i_mem_srcdest_index,
        input  logic [`SHIFT_DATA_W-1:0]  i_mem_srcdest_value,
        input  logic [`SHIFT_DATA_W-1:0]  i_pc_plus_8,
        input  logic                      i_disable_shifter,

        // ALU forward.
        input  logic [`SHIFT_DATA_W-1:0]  i_alu_value_nxt,
        input  logic                      i_alu_dav_nxt,

        output shift_stage_pkg::cond_t    o_condition_code_ff,
        output shift_stage_pkg::alu_op_t  o_alu_operation_ff,
        output logic                      o_flag_update_ff,
        output logic                      o_und_ff,
        output logic [`SHIFT_IDX_W-1:0]   o_destination_index_ff,
        output logic [`SHIFT_DATA_W-1:0]  o_alu_source_value_ff,
        output logic [`SHIFT_DATA_W-1:0]  o_mem_srcdest_value_ff,
        output logic [`SHIFT_DATA_W-1:0]  o_shifted_source_value_ff,
        output logic                      o_shift_carry_ff
);

// Resolved operands and shifter output.
logic [`SHIFT_DATA_W-1:0] alu_value;
logic [`SHIFT_DATA_W-1:0] shift_bypass_value;
logic [`SHIFT_DATA_W-1:0] mem_value;
logic [`SHIFT_DATA_W-1:0] shifted_value;
logic                     shift_carry;

//////////////////////////////////////////////////////////////////////

// Forward compare uses the registered destination.
shift_operand_resolve u_resolve
(
        .i_alu_source         (i_alu_source),
        .i_alu_source_value   (i_alu_source_value),
        .i_shift_source       (i_shift_source),
        .i_shift_source_value (i_shift_source_value),
        .i_mem_srcdest_index  (i_mem_srcdest_index),
        .i_mem_srcdest_value  (i_mem_srcdest_value),
        .i_pc_plus_8          (i_pc_plus_8),
        .i_alu_value_nxt      (i_alu_value_nxt),
        .i_alu_dav_nxt        (i_alu_dav_nxt),
        .i_dest_index_ff      (o_destination_index_ff),
        .o_alu_value          (alu_value),
        .o_shift_bypass_value (shift_bypass_value),
        .o_mem_value          (mem_value)
);

// Shifter works on the unresolved issue value.
shift_barrel u_barrel
(
        .i_source       (i_shift_source_value),
        .i_amount       (i_shift_length_value[`SHIFT_AMT_W-1:0]),
        .i_shift_op     (i_shift_operation),
        .i_carry_ff     (i_cpsr_ff_c),
        .i_carry_nxt    (i_cpsr_nxt_c),
        .i_disable      (i_disable_shifter),
        .i_bypass_value (shift_bypass_value),
        .o_result       (shifted_value),
        .o_carry        (shift_carry)
);

shift_stage_reg u_reg
(
        .i_clk                     (i_clk),
        .i_reset                   (i_reset),
        .i_clear_from_writeback    (i_clear_from_writeback),
        .i_data_stall              (i_data_stall),
        .i_clear_from_alu          (i_clear_from_alu),
        .i_condition_code          (i_condition_code),
        .i_alu_operation           (i_alu_operation),
        .i_flag_update             (i_flag_update),
        .i_und                     (i_und),
        .i_destination_index       (i_destination_index),
        .i_alu_value               (alu_value),
        .i_mem_value               (mem_value),
        .i_shifted_value           (shifted_value),
        .i_shift_carry             (shift_carry),
        .o_condition_code_ff       (o_condition_code_ff),
        .o_alu_operation_ff        (o_alu_operation_ff),
        .o_flag_update_ff          (o_flag_update_ff),
        .o_und_ff                  (o_und_ff),
        .o_destination_index_ff    (o_destination_index_ff),
        .o_alu_source_value_ff     (o_alu_source_value_ff),
        .o_mem_srcdest_value_ff    (o_mem_srcdest_value_ff),
        .o_shifted_source_value_ff (o_shifted_source_value_ff),
        .o_shift_carry_ff          (o_shift_carry_ff)
);

endmodule

// File: source/shift_stage_reg.sv
//////////////////////////////////////////////////////////////////////
// Output register of the shift stage. Priority on each edge is reset,
// clear from writeback, data stall, then clear from ALU.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "shift_stage_params.svh"

module shift_stage_reg
(
        input  logic                      i_clk,
        input  logic                      i_reset,

        // Pipeline control, highest priority first.
        input  logic                      i_clear_from_writeback,
        input  logic                      i_data_stall,
        input  logic                      i_clear_from_alu,

        // Packet fields from issue.
        input  shift_stage_pkg::cond_t    i_condition_code,
        input  shift_stage_pkg::alu_op_t  i_alu_operation,
        input  logic                      i_flag_update,
        input  logic                      i_und,
        input  logic [`SHIFT_IDX_W-1:0]   i_destination_index,

        // Resolved and shifted operands.
        input  logic [`SHIFT_DATA_W-1:0]  i_alu_value,
        input  logic [`SHIFT_DATA_W-1:0]  i_mem_value,
        input  logic [`SHIFT_DATA_W-1:0]  i_shifted_value,
        input  logic                      i_shift_carry,

        output shift_stage_pkg::cond_t    o_condition_code_ff,
        output shift_stage_pkg::alu_op_t  o_alu_operation_ff,
        output logic                      o_flag_update_ff,
        output logic                      o_und_ff,
        output logic [`SHIFT_IDX_W-1:0]   o_destination_index_ff,
        output logic [`SHIFT_DATA_W-1:0]  o_alu_source_value_ff,
        output logic [`SHIFT_DATA_W-1:0]  o_mem_srcdest_value_ff,
        output logic [`SHIFT_DATA_W-1:0]  o_shifted_source_value_ff,
        output logic                      o_shift_carry_ff
);

// Kill the slot. Only the condition and undefined bit change.
task automatic clear;
        o_condition_code_ff <= shift_stage_pkg::NV;
        o_und_ff            <= 1'b0;
endtask

// Everything to zero. EQ and AND both encode as 0.
task automatic reset;
        o_condition_code_ff       <= shift_stage_pkg::EQ;
        o_alu_operation_ff        <= shift_stage_pkg::AND;
        o_flag_update_ff          <= 1'b0;
        o_und_ff                  <= 1'b0;
        o_destination_index_ff    <= '0;
        o_alu_source_value_ff     <= '0;
        o_mem_srcdest_value_ff    <= '0;
        o_shifted_source_value_ff <= '0;
        o_shift_carry_ff          <= 1'b0;
endtask

//////////////////////////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                reset();
        end
        else if (i_clear_from_writeback)
        begin
                clear();
        end
        else if (i_data_stall)
        begin
                // Hold every field.
        end
        else if (i_clear_from_alu)
        begin
                clear();
        end
        else
        begin
                o_condition_code_ff       <= i_condition_code;
                o_alu_operation_ff        <= i_alu_operation;
                o_flag_update_ff          <= i_flag_update;
                o_und_ff                  <= i_und;
                o_destination_index_ff    <= i_destination_index;
                o_alu_source_value_ff     <= i_alu_value;
                o_mem_srcdest_value_ff    <= i_mem_value;
                o_shifted_source_value_ff <= i_shifted_value;
                o_shift_carry_ff          <= i_shift_carry;
        end
end

endmodule

// File: source/shift_barrel.sv
//////////////////////////////////////////////////////////////////////
// Barrel shifter with shifter carry. When the shifter is disabled the
// resolved bypass value and the next carry flag pass straight through.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "shift_stage_params.svh"

module shift_barrel
(
        input  logic [`SHIFT_DATA_W-1:0] i_source,
        input  logic [`SHIFT_AMT_W-1:0]  i_amount,
        input  shift_stage_pkg::shift_op_t i_shift_op,
        input  logic                     i_carry_ff,
        input  logic                     i_carry_nxt,
        input  logic                     i_disable,
        input  logic [`SHIFT_DATA_W-1:0] i_bypass_value,

        output logic [`SHIFT_DATA_W-1:0] o_result,
        output logic                     o_carry
);

// Extended shifts, one spare bit to catch the carry.
logic [`SHIFT_DATA_W:0]        lsl_ext;
logic [`SHIFT_DATA_W:0]        lsr_ext;
logic signed [`SHIFT_DATA_W:0] asr_ext;

// Rotate amount and rotated word.
logic [4:0]                    ror_amt;
logic [`SHIFT_DATA_W-1:0]      ror_word;

// Shifter output before the disable mux.
logic [`SHIFT_DATA_W-1:0]      sh_result;
logic                          sh_carry;

//////////////////////////////////////////////////////////////////////
// Datapath shifts.
//////////////////////////////////////////////////////////////////////

always_comb
begin
        // Carry lands in bit 32. Amount 32 leaves src[0], beyond that 0.
        lsl_ext = {1'b0, i_source} << i_amount;

        // Carry lands in bit 0. Amount 32 leaves src[31] there.
        lsr_ext = {i_source, 1'b0} >> i_amount;

        // Sign fills every bit once the amount reaches 32.
        asr_ext = $signed({i_source, 1'b0}) >>> i_amount;

        // Rotates only look at amount mod 32.
        ror_amt  = i_amount[4:0];
        ror_word = (i_source >> ror_amt) | (i_source << (6'd32 - {1'b0, ror_amt}));
end

//////////////////////////////////////////////////////////////////////
// Select by shift kind. A zero amount keeps the source and carry-in.
//////////////////////////////////////////////////////////////////////

always_comb
begin
        sh_result = i_source;
        sh_carry  = i_carry_ff;

        case (i_shift_op)
        shift_stage_pkg::LSL:
        begin
                if (i_amount != '0)
                begin
                        sh_result = lsl_ext[`SHIFT_DATA_W-1:0];
                        sh_carry  = lsl_ext[`SHIFT_DATA_W];
                end
        end
        shift_stage_pkg::LSR:
        begin
                if (i_amount != '0)
                begin
                        sh_result = lsr_ext[`SHIFT_DATA_W:1];
                        sh_carry  = lsr_ext[0];
                end
        end
        shift_stage_pkg::ASR:
        begin
                if (i_amount != '0)
                begin
                        sh_result = asr_ext[`SHIFT_DATA_W:1];
                        sh_carry  = asr_ext[0];
                end
        end
        shift_stage_pkg::ROR:
        begin
                if (i_amount != '0)
                begin
                        sh_result = ror_word;
                        sh_carry  = ror_word[`SHIFT_DATA_W-1];
                end
        end
        shift_stage_pkg::RRX:
        begin
                // Carry-in rotates into the top bit.
                sh_result = {i_carry_ff, i_source[`SHIFT_DATA_W-1:1]};
                sh_carry  = i_source[0];
        end
        default:
        begin
                // Unused encodings leave the source alone.
        end
        endcase
end

// Disabled shifter: bypass value and the next-state carry.
always_comb
begin
        o_result = i_disable ? i_bypass_value : sh_result;
        o_carry  = i_disable ? i_carry_nxt : sh_carry;
end

endmodule

// File: source/shift_operand_resolve.sv
//////////////////////////////////////////////////////////////////////
// Operand resolution for the shift stage. Picks immediate, pc+8, the
// ALU forward or the issue-read value for each of the three operands.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "shift_stage_params.svh"

module shift_operand_resolve
(
        // Descriptors and values read at issue.
        input  logic [`SHIFT_SRC_W-1:0]  i_alu_source,
        input  logic [`SHIFT_DATA_W-1:0] i_alu_source_value,
        input  logic [`SHIFT_SRC_W-1:0]  i_shift_source,
        input  logic [`SHIFT_DATA_W-1:0] i_shift_source_value,
        input  logic [`SHIFT_IDX_W-1:0]  i_mem_srcdest_index,
        input  logic [`SHIFT_DATA_W-1:0] i_mem_srcdest_value,

        // PC as seen by the instruction.
        input  logic [`SHIFT_DATA_W-1:0] i_pc_plus_8,

        // ALU result about to be written, and its valid bit.
        input  logic [`SHIFT_DATA_W-1:0] i_alu_value_nxt,
        input  logic                     i_alu_dav_nxt,

        // Destination held in this stage's output register.
        input  logic [`SHIFT_IDX_W-1:0]  i_dest_index_ff,

        output logic [`SHIFT_DATA_W-1:0] o_alu_value,
        output logic [`SHIFT_DATA_W-1:0] o_shift_bypass_value,
        output logic [`SHIFT_DATA_W-1:0] o_mem_value
);

// Store index widened into a plain register descriptor.
logic [`SHIFT_SRC_W-1:0] mem_source;

//////////////////////////////////////////////////////////////////////
// One resolution rule, shared by all three operands.
//////////////////////////////////////////////////////////////////////

function automatic logic [`SHIFT_DATA_W-1:0] resolve
(
        input logic [`SHIFT_SRC_W-1:0]  source,
        input logic [`SHIFT_DATA_W-1:0] issue_value
);
        logic [`SHIFT_IDX_W-1:0] index;
        index = source[`SHIFT_IDX_W-1:0];

        if (source[`SHIFT_IMMED_BIT])
        begin
                // Immediate held in the low word.
                resolve = source[`SHIFT_DATA_W-1:0];
        end
        else if (index == `SHIFT_IDX_W'(`SHIFT_PC_INDEX))
        begin
                // PC reads return pc+8.
                resolve = i_pc_plus_8;
        end
        else if (index == i_dest_index_ff && i_alu_dav_nxt)
        begin
                // Older instruction in the ALU writes this register.
                resolve = i_alu_value_nxt;
        end
        else
        begin
                resolve = issue_value;
        end
endfunction

//////////////////////////////////////////////////////////////////////

// The store operand never carries an immediate.
always_comb
begin
        mem_source = '0;
        mem_source[`SHIFT_IDX_W-1:0] = i_mem_srcdest_index;
end

always_comb
begin
        o_alu_value          = resolve(i_alu_source, i_alu_source_value);
        o_shift_bypass_value = resolve(i_shift_source, i_shift_source_value);
        o_mem_value          = resolve(mem_source, i_mem_srcdest_value);
end

endmodule

// File: source/shift_stage_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared enums for the shift stage: shift kinds, ALU opcodes and
// condition codes. Referenced by scoped name from the modules.
//////////////////////////////////////////////////////////////////////

package shift_stage_pkg;

        // Register-controlled shift kinds.
        typedef enum logic [2:0] {
                LSL = 3'd0,
                LSR = 3'd1,
                ASR = 3'd2,
                ROR = 3'd3,
                RRX = 3'd4
        } shift_op_t;

        // ALU opcodes in the classic data-processing order.
        // The stage passes them through untouched.
        typedef enum logic [4:0] {
                AND = 5'd0,  EOR = 5'd1,  SUB = 5'd2,  RSB = 5'd3,
                ADD = 5'd4,  ADC = 5'd5,  SBC = 5'd6,  RSC = 5'd7,
                TST = 5'd8,  TEQ = 5'd9,  CMP = 5'd10, CMN = 5'd11,
                ORR = 5'd12, MOV = 5'd13, BIC = 5'd14, MVN = 5'd15
        } alu_op_t;

        // Condition codes. NV marks a killed slot.
        typedef enum logic [3:0] {
                EQ = 4'd0,  NE = 4'd1,  CS = 4'd2,  CC = 4'd3,
                MI = 4'd4,  PL = 4'd5,  VS = 4'd6,  VC = 4'd7,
                HI = 4'd8,  LS = 4'd9,  GE = 4'd10, LT = 4'd11,
                GT = 4'd12, LE = 4'd13, AL = 4'd14, NV = 4'd15
        } cond_t;

endpackage

// File: include/shift_stage_params.svh
//////////////////////////////////////////////////////////////////////
// Widths and fixed indices for the shift stage pipeline.
// Included by every shift stage module that sizes a port or a field.
//////////////////////////////////////////////////////////////////////

`ifndef SHIFT_STAGE_PARAMS_SVH
`define SHIFT_STAGE_PARAMS_SVH

// Data word width.
`define SHIFT_DATA_W 32

// Architectural registers and the index width that covers them.
`define SHIFT_REG_COUNT 16
`define SHIFT_IDX_W $clog2(`SHIFT_REG_COUNT)

// Register index that reads as the PC (pc+8).
`define SHIFT_PC_INDEX 15

// Operand descriptor: immediate flag on top, value or index below.
`define SHIFT_SRC_W 33
`define SHIFT_IMMED_BIT 32

// Low bits of the shift length that form the shift amount.
`define SHIFT_AMT_W 8

`endif
